// File: design/rob_alloc.sv
`timescale 1ns/1ps
`include "rob_cfg.svh"

module rob_alloc (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              alloc_vld,
    input  logic              flush,
    input  rob_pkg::rob_idx_t rollback,
    output rob_pkg::rob_ptr_t tail,
    output rob_pkg::grp_cnt_t squash_grps
);
    import rob_pkg::*;

    rob_idx_t tail_idx;
    rob_idx_t back_dist;
    rob_ptr_t tail_nxt;

    assign tail_idx = tail[`ROB_IDX_W-1:0];

    // entries between the rollback point and the current tail, always whole groups
    assign back_dist = tail_idx - rollback;

    // a group arriving together with the flush is younger than the branch,
    // so it is dropped and its credit goes back with the squashed ones
    always_comb begin
        if (flush) begin
            squash_grps = grp_cnt_t'(back_dist / `ROB_WIDTH) + grp_cnt_t'(alloc_vld);
        end else begin
            squash_grps = '0;
        end
    end

    // subtracting on the full pointer flips the wrap bit when the rollback
    // crosses entry 0
    always_comb begin
        if (flush) begin
            tail_nxt = tail - rob_ptr_t'(back_dist);
        end else if (alloc_vld) begin
            tail_nxt = tail + rob_ptr_t'(`ROB_WIDTH);
        end else begin
            tail_nxt = tail;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tail <= '0;
        end else begin
            tail <= tail_nxt;
        end
    end

endmodule

// File: design/rob_branch_resolve.sv
`timescale 1ns/1ps
`include "rob_cfg.svh"

module rob_branch_resolve (
    input  rob_pkg::brnc_res_t              brnc_res,
    input  rob_pkg::entry_vec_t             brnc,
    input  rob_pkg::entry_vec_t             pred,
    input  rob_pkg::entry_vec_t             done,
    input  rob_pkg::cond_t [`ROB_DEPTH-1:0] cond,
    input  rob_pkg::pc_t   [`ROB_DEPTH-1:0] rcvr_pc,
    output logic                            flush,
    output rob_pkg::rob_idx_t               keep_end,
    output rob_pkg::rob_idx_t               rollback,
    output rob_pkg::brnc_ev_t               brnc_ev
);
    import rob_pkg::*;

    rob_idx_t idx;
    logic     resolve;
    logic     cond_met;
    logic     mis;

    assign idx = brnc_res.idx;

    // only an unfinished branch entry accepts a result
    assign resolve  = (brnc_res.rslt != '0) && brnc[idx] && !done[idx];
    assign cond_met = (cond[idx] == brnc_res.rslt);
    assign mis      = resolve && (pred[idx] != cond_met);

    assign flush    = mis;
    assign keep_end = idx;
    // first entry of the group after the branch
    assign rollback = rob_idx_t'((idx | rob_idx_t'(`ROB_WIDTH - 1)) + rob_idx_t'(1));

    assign brnc_ev.mis     = mis;
    assign brnc_ev.ok      = resolve && !mis;
    assign brnc_ev.pred    = resolve && pred[idx];
    assign brnc_ev.rcvr_pc = mis ? rcvr_pc[idx] : '0;

endmodule

// File: design/rob_cfg.svh
`ifndef ROB_CFG_SVH
`define ROB_CFG_SVH

// buffer geometry
`define ROB_DEPTH   64
`define ROB_WIDTH   4
`define ROB_GROUPS  16

// field widths
`define ROB_IDX_W   6
`define PREG_W      6
`define PC_W        16

// mult, alu1, alu2, load
`define N_CMPL      4

`endif

// File: design/rob_commit.sv
`timescale 1ns/1ps
`include "rob_cfg.svh"

module rob_commit (
    input  logic                            clk,
    input  logic                            rst_n,
    input  rob_pkg::entry_vec_t             vld,
    input  rob_pkg::entry_vec_t             done,
    input  rob_pkg::entry_vec_t             reg_wrt,
    input  rob_pkg::entry_vec_t             brnc,
    input  rob_pkg::preg_t [`ROB_DEPTH-1:0] preg,
    input  rob_pkg::rob_ptr_t               tail,
    input  rob_pkg::grp_cnt_t               squash_grps,
    output rob_pkg::rob_ptr_t               head,
    output rob_pkg::slot_cnt_t              cmt_cnt,
    output rob_pkg::commit_t                commit,
    output rob_pkg::grp_cnt_t               cred_ret,
    output logic                            rob_empty
);
    import rob_pkg::*;

    rob_idx_t              head_idx;
    rob_idx_t              win_idx [`ROB_WIDTH];
    logic [`ROB_WIDTH-1:0] win_ok;
    logic                  run;
    slot_cnt_t             n_free;
    slot_cnt_t             head_slot;
    logic                  grp_done;
    rob_ptr_t              head_nxt;

    assign head_idx = head[`ROB_IDX_W-1:0];

    // commit window, four entries from the head
    always_comb begin
        for (int k = 0; k < `ROB_WIDTH; k++) begin
            win_idx[k] = head_idx + rob_idx_t'(k);
            // plain entries need no completion
            win_ok[k]  = vld[win_idx[k]] &&
                         (done[win_idx[k]] || !(reg_wrt[win_idx[k]] || brnc[win_idx[k]]));
        end
    end

    // leading run of committable entries
    always_comb begin
        run     = 1'b1;
        cmt_cnt = '0;
        for (int k = 0; k < `ROB_WIDTH; k++) begin
            run = run && win_ok[k];
            if (run) begin
                cmt_cnt = cmt_cnt + slot_cnt_t'(1);
            end
        end
    end

    // freed registers packed from slot 0 upward, in program order
    always_comb begin
        n_free           = '0;
        commit.free_preg = '0;
        for (int k = 0; k < `ROB_WIDTH; k++) begin
            if ((slot_cnt_t'(k) < cmt_cnt) && reg_wrt[win_idx[k]]) begin
                commit.free_preg[n_free] = preg[win_idx[k]];
                n_free = n_free + slot_cnt_t'(1);
            end
        end
        commit.free_cnt = n_free;
    end

    assign head_nxt  = head + rob_ptr_t'(cmt_cnt);
    assign head_slot = slot_cnt_t'(head_idx % `ROB_WIDTH);

    // at most one group boundary is passed per cycle
    assign grp_done = (head_slot + cmt_cnt) >= slot_cnt_t'(`ROB_WIDTH);
    assign cred_ret = squash_grps + grp_cnt_t'(grp_done);

    // wrap bit tells full from empty
    assign rob_empty = (head == tail);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head <= '0;
        end else begin
            head <= head_nxt;
        end
    end

endmodule

// File: design/rob_entry_array.sv
`timescale 1ns/1ps
`include "rob_cfg.svh"

module rob_entry_array (
    input  logic                            clk,
    input  logic                            rst_n,
    input  rob_pkg::alloc_grp_t             alloc,
    input  rob_pkg::rob_ptr_t               tail,
    input  rob_pkg::cmpl_vec_t              cmpl,
    input  logic                            flush,
    input  rob_pkg::rob_idx_t               keep_end,
    input  rob_pkg::rob_idx_t               rollback,
    input  rob_pkg::rob_ptr_t               head,
    input  rob_pkg::slot_cnt_t              cmt_cnt,
    input  logic                            ok_brnc,
    input  rob_pkg::rob_idx_t               ok_idx,
    output rob_pkg::entry_vec_t             vld,
    output rob_pkg::entry_vec_t             done,
    output rob_pkg::entry_vec_t             reg_wrt,
    output rob_pkg::entry_vec_t             brnc,
    output rob_pkg::entry_vec_t             pred,
    output rob_pkg::cond_t [`ROB_DEPTH-1:0] cond,
    output rob_pkg::pc_t   [`ROB_DEPTH-1:0] rcvr_pc,
    output rob_pkg::preg_t [`ROB_DEPTH-1:0] preg
);
    import rob_pkg::*;

    rob_idx_t   tail_idx;
    rob_idx_t   head_idx;
    rob_idx_t   squash_len;
    rob_idx_t   plain_len;
    entry_vec_t wr_mask;
    entry_vec_t squash_mask;
    entry_vec_t plain_mask;
    entry_vec_t cmt_mask;
    entry_vec_t done_set;

    // distance around the ring from one entry to another
    function automatic rob_idx_t ring_dist(rob_idx_t from, rob_idx_t to);
        return rob_idx_t'(to - from);
    endfunction

    assign tail_idx = tail[`ROB_IDX_W-1:0];
    assign head_idx = head[`ROB_IDX_W-1:0];

    assign squash_len = ring_dist(rollback, tail_idx);
    assign plain_len  = ring_dist(keep_end, rollback);

    always_comb begin
        for (int i = 0; i < `ROB_DEPTH; i++) begin
            // allocation is dropped while a flush is in progress
            wr_mask[i] = alloc.vld && !flush &&
                         (ring_dist(tail_idx, rob_idx_t'(i)) < rob_idx_t'(`ROB_WIDTH));
            // whole younger groups
            squash_mask[i] = flush && (ring_dist(rollback, rob_idx_t'(i)) < squash_len);
            // rest of the branch's own group turns into plain entries
            plain_mask[i] = flush && (ring_dist(keep_end, rob_idx_t'(i)) != '0) &&
                            (ring_dist(keep_end, rob_idx_t'(i)) < plain_len);
            cmt_mask[i] = ring_dist(head_idx, rob_idx_t'(i)) < rob_idx_t'(cmt_cnt);
        end
    end

    always_comb begin
        done_set = '0;
        for (int p = 0; p < `N_CMPL; p++) begin
            if (cmpl[p].vld) begin
                done_set[cmpl[p].idx] = 1'b1;
            end
        end
        if (ok_brnc) begin
            done_set[ok_idx] = 1'b1;
        end
        // a mispredicted branch is resolved as well and must not block the head
        if (flush) begin
            done_set[keep_end] = 1'b1;
        end
    end

    // status flags
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld     <= '0;
            done    <= '0;
            reg_wrt <= '0;
            brnc    <= '0;
        end else begin
            for (int i = 0; i < `ROB_DEPTH; i++) begin
                if (wr_mask[i]) begin
                    vld[i]     <= 1'b1;
                    done[i]    <= 1'b0;
                    reg_wrt[i] <= alloc.slot[i % `ROB_WIDTH].reg_wrt;
                    brnc[i]    <= alloc.slot[i % `ROB_WIDTH].brnc;
                end else if (squash_mask[i] || cmt_mask[i]) begin
                    // squash wins over a completion on the same edge
                    vld[i]  <= 1'b0;
                    done[i] <= 1'b0;
                end else if (done_set[i]) begin
                    done[i] <= 1'b1;
                end
                if (plain_mask[i]) begin
                    reg_wrt[i] <= 1'b0;
                    brnc[i]    <= 1'b0;
                end
            end
        end
    end

    // instruction payload
    always_ff @(posedge clk) begin
        for (int i = 0; i < `ROB_DEPTH; i++) begin
            if (wr_mask[i]) begin
                pred[i]    <= alloc.slot[i % `ROB_WIDTH].pred;
                cond[i]    <= alloc.slot[i % `ROB_WIDTH].cond;
                rcvr_pc[i] <= alloc.slot[i % `ROB_WIDTH].rcvr_pc;
                preg[i]    <= alloc.slot[i % `ROB_WIDTH].preg;
            end
        end
    end

endmodule

// File: design/rob_pkg.sv
`include "rob_cfg.svh"

package rob_pkg;

    typedef logic [`ROB_IDX_W-1:0] rob_idx_t;
    // msb is the wrap bit
    typedef logic [`ROB_IDX_W:0] rob_ptr_t;
    typedef logic [`PREG_W-1:0] preg_t;
    typedef logic [`PC_W-1:0] pc_t;
    // same encoding as the compare result from the register file
    typedef logic [1:0] cond_t;
    typedef logic [$clog2(`ROB_GROUPS+1)-1:0] grp_cnt_t;
    typedef logic [$clog2(`ROB_WIDTH+1)-1:0] slot_cnt_t;
    typedef logic [`ROB_DEPTH-1:0] entry_vec_t;

    typedef struct packed {
        logic   reg_wrt;
        preg_t  preg;
        logic   brnc;
        logic   pred;
        cond_t  cond;
        pc_t    rcvr_pc;
    } alloc_slot_t;

    // slot 0 is the oldest instruction of the group
    typedef struct packed {
        logic                             vld;
        alloc_slot_t [`ROB_WIDTH-1:0]     slot;
    } alloc_grp_t;

    typedef struct packed {
        logic     vld;
        rob_idx_t idx;
    } cmpl_t;

    typedef cmpl_t [`N_CMPL-1:0] cmpl_vec_t;

    // rslt of zero means no branch resolved this cycle
    typedef struct packed {
        rob_idx_t idx;
        cond_t    rslt;
    } brnc_res_t;

    typedef struct packed {
        logic mis;
        logic ok;
        logic pred;
        pc_t  rcvr_pc;
    } brnc_ev_t;

    typedef struct packed {
        slot_cnt_t                  free_cnt;
        preg_t [`ROB_WIDTH-1:0]     free_preg;
    } commit_t;

endpackage

// File: design/rob_top.sv
`timescale 1ns/1ps
`include "rob_cfg.svh"

module rob_top (
    input  logic                clk,
    input  logic                rst_n,
    input  rob_pkg::alloc_grp_t alloc,
    input  rob_pkg::cmpl_vec_t  cmpl,
    input  rob_pkg::brnc_res_t  brnc_res,
    output rob_pkg::rob_ptr_t   next_ptr,
    output rob_pkg::grp_cnt_t   cred_ret,
    output rob_pkg::commit_t    commit,
    output rob_pkg::brnc_ev_t   brnc_ev,
    output logic                rob_empty
);
    import rob_pkg::*;

    // per-entry state
    entry_vec_t                 vld;
    entry_vec_t                 done;
    entry_vec_t                 reg_wrt;
    entry_vec_t                 brnc;
    entry_vec_t                 pred;
    cond_t [`ROB_DEPTH-1:0]     cond;
    pc_t   [`ROB_DEPTH-1:0]     rcvr_pc;
    preg_t [`ROB_DEPTH-1:0]     preg;

    // recovery
    logic                       flush;
    rob_idx_t                   keep_end;
    rob_idx_t                   rollback;
    grp_cnt_t                   squash_grps;

    // retirement
    rob_ptr_t                   head;
    slot_cnt_t                  cmt_cnt;

    rob_alloc u_alloc (
        .clk         (clk),
        .rst_n       (rst_n),
        .alloc_vld   (alloc.vld),
        .flush       (flush),
        .rollback    (rollback),
        .tail        (next_ptr),
        .squash_grps (squash_grps)
    );

    rob_entry_array u_entry_array (
        .clk      (clk),
        .rst_n    (rst_n),
        .alloc    (alloc),
        .tail     (next_ptr),
        .cmpl     (cmpl),
        .flush    (flush),
        .keep_end (keep_end),
        .rollback (rollback),
        .head     (head),
        .cmt_cnt  (cmt_cnt),
        .ok_brnc  (brnc_ev.ok),
        .ok_idx   (brnc_res.idx),
        .vld      (vld),
        .done     (done),
        .reg_wrt  (reg_wrt),
        .brnc     (brnc),
        .pred     (pred),
        .cond     (cond),
        .rcvr_pc  (rcvr_pc),
        .preg     (preg)
    );

    rob_branch_resolve u_branch_resolve (
        .brnc_res (brnc_res),
        .brnc     (brnc),
        .pred     (pred),
        .done     (done),
        .cond     (cond),
        .rcvr_pc  (rcvr_pc),
        .flush    (flush),
        .keep_end (keep_end),
        .rollback (rollback),
        .brnc_ev  (brnc_ev)
    );

    rob_commit u_commit (
        .clk         (clk),
        .rst_n       (rst_n),
        .vld         (vld),
        .done        (done),
        .reg_wrt     (reg_wrt),
        .brnc        (brnc),
        .preg        (preg),
        .tail        (next_ptr),
        .squash_grps (squash_grps),
        .head        (head),
        .cmt_cnt     (cmt_cnt),
        .commit      (commit),
        .cred_ret    (cred_ret),
        .rob_empty   (rob_empty)
    );

endmodule

// File: rob_project.f
+incdir+design
design/rob_pkg.sv
design/rob_alloc.sv
design/rob_entry_array.sv
design/rob_branch_resolve.sv
design/rob_commit.sv
design/rob_top.sv
tb/tb_rob.sv

// File: run_sim.sh
#!/bin/bash
set -e
set -o pipefail
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module tb_rob -f rob_project.f -o sim_rob
./obj_dir/sim_rob | tee sim.log

if grep -qF '*** FAILED ***' sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
echo "simulation finished without failure"

// File: tb/rob_golden.txt
# one record per cycle, hex fields; rep repeats the record, np ff skips the tail check
# tst rep av rw br pr cd pc pb c0 c1 c2 c3 bi rs | expect cr fc f0 f1 f2 f3 mi ok rpc em np
1 1 0 0 0 0 0 0000 00 00 00 00 00 00 0  0 0 00 00 00 00 0 0 0000 1 00
1 1 1 0 0 0 0 0000 00 00 00 00 00 00 0  0 0 00 00 00 00 0 0 0000 1 00
1 1 0 0 0 0 0 0000 00 00 00 00 00 00 0  1 0 00 00 00 00 0 0 0000 0 04
2 1 1 f 0 0 0 0000 10 00 00 00 00 00 0  0 0 00 00 00 00 0 0 0000 1 04
2 1 0 0 0 0 0 0000 00 00 00 47 45 00 0  0 0 00 00 00 00 0 0 0000 0 08
2 1 0 0 0 0 0 0000 00 46 00 00 00 00 0  0 0 00 00 00 00 0 0 0000 0 08
2 1 0 0 0 0 0 0000 00 00 44 00 00 00 0  0 0 00 00 00 00 0 0 0000 0 08
2 1 0 0 0 0 0 0000 00 00 00 00 00 00 0  1 4 10 11 12 13 0 0 0000 0 08
3 1 1 f 0 0 0 0000 20 00 00 00 00 00 0  0 0 00 00 00 00 0 0 0000 1 08
3 1 0 0 0 0 0 0000 00 48 4a 00 00 00 0  0 0 00 00 00 00 0 0 0000 0 0c
3 1 0 0 0 0 0 0000 00 00 00 00 00 00 0  0 1 20 00 00 00 0 0 0000 0 0c
3 1 0 0 0 0 0 0000 00 00 00 00 49 00 0  0 0 00 00 00 00 0 0 0000 0 0c
3 1 0 0 0 0 0 0000 00 00 00 00 00 00 0  0 2 21 22 00 00 0 0 0000 0 0c
3 1 0 0 0 0 0 0000 00 00 00 4b 00 00 0  0 0 00 00 00 00 0 0 0000 0 0c
3 1 0 0 0 0 0 0000 00 00 00 00 00 00 0  1 1 23 00 00 00 0 0 0000 0 0c
4 1 1 0 2 2 1 1234 00 00 00 00 00 00 0  0 0 00 00 00 00 0 0 0000 1 0c
4 1 0 0 0 0 0 0000 00 00 00 00 00 0d 1  0 0 00 00 00 00 0 1 0000 0 10
4 1 0 0 0 0 0 0000 00 00 00 00 00 00 0  1 0 00 00 00 00 0 0 0000 0 10
5 1 1 d 2 0 2 abcd 30 00 00 00 00 00 0  0 0 00 00 00 00 0 0 0000 1 10
5 1 1 f 0 0 0 0000 34 00 00 00 00 00 0  0 0 00 00 00 00 0 0 0000 0 14
5 1 1 f 0 0 0 0000 38 00 00 00 00 00 0  0 0 00 00 00 00 0 0 0000 0 18
5 1 0 0 0 0 0 0000 00 50 00 00 00 11 2  2 0 00 00 00 00 1 0 abcd 0 1c
5 1 0 0 0 0 0 0000 00 00 00 00 00 00 0  1 1 30 00 00 00 0 0 0000 0 14
6 1 1 0 0 0 0 0000 00 00 00 00 00 00 0  0 0 00 00 00 00 0 0 0000 1 14
6 13 1 0 0 0 0 0000 00 00 00 00 00 00 0  1 0 00 00 00 00 0 0 0000 0 ff
6 1 0 0 0 0 0 0000 00 00 00 00 00 00 0  1 0 00 00 00 00 0 0 0000 0 64

// File: tb/tb_rob.sv
`timescale 1ns/1ps
`include "rob_cfg.svh"

module tb_rob;
    import rob_pkg::*;

    // one record of the golden file
    typedef struct packed {
        logic [3:0]                 tst;
        logic [7:0]                 rep;
        logic                       av;
        logic [`ROB_WIDTH-1:0]      rw;
        logic [`ROB_WIDTH-1:0]      br;
        logic [`ROB_WIDTH-1:0]      pr;
        cond_t                      cd;
        pc_t                        pc;
        preg_t                      pb;
        cmpl_vec_t                  cm;
        rob_idx_t                   bi;
        cond_t                      rs;
        grp_cnt_t                   cr;
        slot_cnt_t                  fc;
        preg_t [`ROB_WIDTH-1:0]     fp;
        logic                       mi;
        logic                       ok;
        pc_t                        rpc;
        logic                       em;
        logic [7:0]                 np;
    } gold_rec_t;

    logic       clk;
    logic       rst_n;
    alloc_grp_t alloc;
    cmpl_vec_t  cmpl;
    brnc_res_t  brnc_res;
    rob_ptr_t   next_ptr;
    grp_cnt_t   cred_ret;
    commit_t    commit;
    brnc_ev_t   brnc_ev;
    logic       rob_empty;

    gold_rec_t  recs[$];
    int         credits;
    int         errs;
    int         test_errs;
    int         n_checks;
    int         tests_run;
    int         tests_failed;
    logic       timed_out;

    // predictions as allocated, indexed by entry
    logic [`ROB_DEPTH-1:0] exp_pred;
    int                    model_tail;

    rob_top uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .alloc     (alloc),
        .cmpl      (cmpl),
        .brnc_res  (brnc_res),
        .next_ptr  (next_ptr),
        .cred_ret  (cred_ret),
        .commit    (commit),
        .brnc_ev   (brnc_ev),
        .rob_empty (rob_empty)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    task automatic compare_val(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            $display("ERR %0t %s got %0h expected %0h", $time, name, got, exp);
            errs++;
            test_errs++;
        end
    endtask

    task automatic set_idle();
        alloc    = '0;
        cmpl     = '0;
        brnc_res = '0;
    endtask

    task automatic read_golden();
        int          fd;
        int          n;
        string       line;
        int unsigned f [26];
        gold_rec_t   rec;
        fd = $fopen("tb/rob_golden.txt", "r");
        if (fd == 0) begin
            $display("cannot open the golden file tb/rob_golden.txt");
            errs++;
            return;
        end
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            // skip comment and empty lines
            if (n > 1 && line.getc(0) != 8'h23) begin
                n = $sscanf(line,
                    "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                            f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
                            f[9], f[10], f[11], f[12], f[13], f[14], f[15], f[16],
                            f[17], f[18], f[19], f[20], f[21], f[22], f[23], f[24], f[25]);
                if (n != 26) begin
                    $display("golden line has %0d fields instead of 26: %s", n, line);
                    errs++;
                end else begin
                    rec.tst = f[0][3:0];
                    rec.rep = f[1][7:0];
                    rec.av  = f[2][0];
                    rec.rw  = f[3][3:0];
                    rec.br  = f[4][3:0];
                    rec.pr  = f[5][3:0];
                    rec.cd  = f[6][1:0];
                    rec.pc  = f[7][15:0];
                    rec.pb  = f[8][5:0];
                    for (int k = 0; k < `ROB_WIDTH; k++) begin
                        rec.cm[k] = cmpl_t'(f[9 + k][6:0]);
                        rec.fp[k] = f[17 + k][5:0];
                    end
                    rec.bi  = f[13][5:0];
                    rec.rs  = f[14][1:0];
                    rec.cr  = f[15][4:0];
                    rec.fc  = f[16][2:0];
                    rec.mi  = f[21][0];
                    rec.ok  = f[22][0];
                    rec.rpc = f[23][15:0];
                    rec.em  = f[24][0];
                    rec.np  = f[25][7:0];
                    recs.push_back(rec);
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic drive_record(input gold_rec_t rec);
        alloc.vld = rec.av;
        for (int k = 0; k < `ROB_WIDTH; k++) begin
            alloc.slot[k].reg_wrt = rec.rw[k];
            alloc.slot[k].brnc    = rec.br[k];
            alloc.slot[k].pred    = rec.pr[k];
            alloc.slot[k].cond    = rec.cd;
            alloc.slot[k].rcvr_pc = rec.pc;
            // writing slots count up from the base, idle slots get noise
            if (rec.rw[k]) begin
                alloc.slot[k].preg = rec.pb + preg_t'(k);
            end else begin
                alloc.slot[k].preg = preg_t'($urandom);
            end
        end
        cmpl          = rec.cm;
        brnc_res.idx  = rec.bi;
        brnc_res.rslt = rec.rs;
    endtask

    task automatic run_cycle(input gold_rec_t rec);
        logic exp_p;
        @(posedge clk);
        #2;
        if (rec.av) begin
            if (credits == 0) begin
                $display("credit underflow: group sent with no credit left in test %0d", rec.tst);
                errs++;
                test_errs++;
            end else begin
                credits--;
            end
        end
        drive_record(rec);
        // sample just before the next rising edge
        #36;
        compare_val("cred_ret", 32'(cred_ret), 32'(rec.cr));
        compare_val("free_cnt", 32'(commit.free_cnt), 32'(rec.fc));
        for (int k = 0; k < `ROB_WIDTH; k++) begin
            compare_val($sformatf("free_preg[%0d]", k), 32'(commit.free_preg[k]),
                        32'(rec.fp[k]));
        end
        compare_val("brnc_ev.mis", 32'(brnc_ev.mis), 32'(rec.mi));
        compare_val("brnc_ev.ok", 32'(brnc_ev.ok), 32'(rec.ok));
        compare_val("brnc_ev.rcvr_pc", 32'(brnc_ev.rcvr_pc), 32'(rec.rpc));
        // a resolved branch reports the prediction stored at allocation
        exp_p = (rec.mi || rec.ok) ? exp_pred[rec.bi] : 1'b0;
        compare_val("brnc_ev.pred", 32'(brnc_ev.pred), 32'(exp_p));
        compare_val("rob_empty", 32'(rob_empty), 32'(rec.em));
        // ff marks a cycle where the tail is not checked
        if (rec.np != 8'hff) begin
            compare_val("next_ptr", 32'(next_ptr), 32'(rec.np));
        end
        credits += int'(cred_ret);
        // tail moves at the edge, back to the group after a mispredicted branch
        if (rec.mi) begin
            model_tail = ((int'(rec.bi) | (`ROB_WIDTH - 1)) + 1) % `ROB_DEPTH;
        end else if (rec.av) begin
            for (int k = 0; k < `ROB_WIDTH; k++) begin
                exp_pred[(model_tail + k) % `ROB_DEPTH] = rec.pr[k];
            end
            model_tail = (model_tail + `ROB_WIDTH) % `ROB_DEPTH;
        end
    endtask

    task automatic wait_empty(input int tst);
        int cycles;
        cycles = 0;
        do begin
            @(posedge clk);
            #2;
            set_idle();
            #36;
            credits += int'(cred_ret);
            cycles++;
        end while (!rob_empty && cycles < 32);
        if (!rob_empty) begin
            $display("timeout: rob_empty stayed low for %0d cycles in test %0d", cycles, tst);
            errs++;
            test_errs++;
            timed_out = 1'b1;
        end
    endtask

    task automatic finish_test(input int tst);
        wait_empty(tst);
        // an empty buffer owes every credit back
        compare_val("credits", 32'(credits), 32'(`ROB_GROUPS));
        tests_run++;
        if (test_errs == 0) begin
            $display("test %0d done, no errors", tst);
        end else begin
            $display("test %0d done, %0d errors", tst, test_errs);
            tests_failed++;
        end
        test_errs = 0;
    endtask

    initial begin
        int idx;
        rst_n        = 1'b0;
        set_idle();
        errs         = 0;
        test_errs    = 0;
        n_checks     = 0;
        tests_run    = 0;
        tests_failed = 0;
        timed_out    = 1'b0;
        credits      = 0;
        exp_pred     = '0;
        model_tail   = 0;
        void'($urandom(76));
        read_golden();
        repeat (3) @(posedge clk);
        #2;
        rst_n   = 1'b1;
        credits = `ROB_GROUPS;
        if (recs.size() == 0) begin
            $display("golden file holds no records");
            errs++;
        end
        idx = 0;
        while (idx < recs.size() && !timed_out) begin
            repeat (recs[idx].rep) run_cycle(recs[idx]);
            if (idx + 1 == recs.size() || recs[idx + 1].tst != recs[idx].tst) begin
                finish_test(int'(recs[idx].tst));
            end
            idx++;
        end
        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, n_checks, errs);
        if (errs == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule
